// File: source/fp_add_pkg.sv
/*
 * Shared definitions for the multi-lane single-precision adder.
 * Lane count and field widths, the operand word seen as bits or fields,
 * and the records passed from stage to stage.
 */
package fp_add_pkg;

	// Vector width and thread tag
	localparam int lanes = 4;
	localparam int tag_width = 4;

	// IEEE single field widths, significand includes the hidden bit
	localparam int exp_width = 8;
	localparam int sig_width = 24;

	// Issue to result, in cycles
	localparam int pipe_latency = 4;

	// Alignment shift distance, saturated at max_shift
	localparam int shift_width = 5;
	localparam int max_shift = (1 << shift_width) - 1;

	// Largest finite exponent, used when saturating on overflow
	localparam logic [exp_width-1:0] exp_max = 8'hfe;

	typedef struct packed {
		logic sign;
		logic [exp_width-1:0] exponent;
		logic [sig_width-2:0] fraction;
	} fp_fields_t;

	// One operand or result word, raw or split into fields
	typedef union packed {
		logic [exp_width+sig_width-1:0] bits;
		fp_fields_t fields;
	} fp_word_t;

	// Control that travels beside the lane data
	typedef struct packed {
		logic valid;
		logic [lanes-1:0] mask;
		logic [tag_width-1:0] tag;
	} pipe_ctl_t;

	// Stage 1 to stage 2
	typedef struct packed {
		logic [sig_width-1:0] large_sig;
		logic [sig_width-1:0] small_sig;
		logic [shift_width-1:0] shift_dist;
		logic [exp_width-1:0] exponent;
		logic logical_subtract;
		logic result_sign;
		logic zero;
	} align_lane_t;

	// Stage 2 to stage 3
	typedef struct packed {
		logic [sig_width-1:0] significand1;
		logic [sig_width-1:0] significand2;
		logic [exp_width-1:0] exponent;
		logic guard;
		logic round;
		logic sticky;
		logic logical_subtract;
		logic result_sign;
		logic zero;
	} shift_lane_t;

	// Stage 3 to stage 4, sum has one extra bit for carry-out
	typedef struct packed {
		logic [sig_width:0] sum;
		logic [exp_width-1:0] exponent;
		logic guard;
		logic round;
		logic sticky;
		logic logical_subtract;
		logic result_sign;
		logic zero;
	} sum_lane_t;

endpackage

// File: source/fp_add_align.sv
/*
 * Adder stage 1: unpack and order operands.
 * Flushes denormals, restores hidden bits, puts the larger magnitude first
 * and works out shift distance, effective operation and result sign.
 */
`timescale 1ns/1ps

module fp_add_align
	import fp_add_pkg::*;
(
	input  logic                        clk,
	input  logic                        reset,
	input  pipe_ctl_t                   issue_ctl,
	input  logic                        subtract,
	input  fp_word_t [lanes-1:0]        operand_a,
	input  fp_word_t [lanes-1:0]        operand_b,
	output pipe_ctl_t                   align_ctl,
	output align_lane_t [lanes-1:0]     align_lanes
);

	align_lane_t [lanes-1:0] lane_next;

	always_comb
	begin
		fp_fields_t a;
		fp_fields_t b;
		logic a_zero;
		logic b_zero;
		logic [exp_width+sig_width-2:0] a_mag;
		logic [exp_width+sig_width-2:0] b_mag;
		logic [sig_width-1:0] a_sig;
		logic [sig_width-1:0] b_sig;
		logic swap;
		logic [exp_width-1:0] exp_large;
		logic [exp_width-1:0] exp_small;
		logic [exp_width-1:0] exp_diff;

		for (int i = 0; i < lanes; i++)
		begin
			a = operand_a[i].fields;
			b = operand_b[i].fields;

			// Exponent zero means zero or denormal, both read as zero
			a_zero = a.exponent == '0;
			b_zero = b.exponent == '0;
			a_sig = a_zero ? '0 : {1'b1, a.fraction};
			b_sig = b_zero ? '0 : {1'b1, b.fraction};

			// Magnitude compare on exponent then fraction
			a_mag = a_zero ? '0 : {a.exponent, a.fraction};
			b_mag = b_zero ? '0 : {b.exponent, b.fraction};
			swap = b_mag > a_mag;

			exp_large = swap ? b.exponent : a.exponent;
			exp_small = swap ? a.exponent : b.exponent;
			exp_diff = exp_large - exp_small;

			lane_next[i].large_sig = swap ? b_sig : a_sig;
			lane_next[i].small_sig = swap ? a_sig : b_sig;
			// Beyond max_shift everything lands in sticky anyway
			lane_next[i].shift_dist = (exp_diff > max_shift) ? shift_width'(max_shift)
				: exp_diff[shift_width-1:0];
			lane_next[i].exponent = exp_large;
			lane_next[i].logical_subtract = a.sign ^ b.sign ^ subtract;
			// Sign follows the larger operand, b flipped for subtract
			lane_next[i].result_sign = swap ? (b.sign ^ subtract) : a.sign;
			lane_next[i].zero = swap ? b_zero : a_zero;
		end
	end

	always_ff @(posedge clk)
	begin
		align_lanes <= lane_next;
	end

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			align_ctl <= '0;
		end
		else
		begin
			align_ctl <= issue_ctl;
		end
	end

	// Issuer must never leave valid floating once out of reset
	assert property (@(posedge clk) disable iff (reset) !$isunknown(issue_ctl.valid))
		else $error("Issue valid is unknown at time %0t", $time);

endmodule

// File: source/fp_add_shift.sv
/*
 * Adder stage 2: alignment.
 * Shifts the smaller significand right by the exponent difference and
 * collects guard, round and sticky from the bits that fall off.
 */
`timescale 1ns/1ps

module fp_add_shift
	import fp_add_pkg::*;
(
	input  logic                        clk,
	input  logic                        reset,
	input  pipe_ctl_t                   align_ctl,
	input  align_lane_t [lanes-1:0]     align_lanes,
	output pipe_ctl_t                   shift_ctl,
	output shift_lane_t [lanes-1:0]     shift_lanes
);

	shift_lane_t [lanes-1:0] lane_next;

	always_comb
	begin
		align_lane_t cur;
		logic [sig_width+max_shift-1:0] wide;

		for (int i = 0; i < lanes; i++)
		begin
			cur = align_lanes[i];

			// Room below the significand for every bit a full shift can push out
			wide = {cur.small_sig, {max_shift{1'b0}}} >> cur.shift_dist;

			lane_next[i].significand1 = cur.large_sig;
			lane_next[i].significand2 = wide[sig_width+max_shift-1 -: sig_width];

			// First two lost bits kept apart, the rest folded into sticky
			lane_next[i].guard = wide[max_shift-1];
			lane_next[i].round = wide[max_shift-2];
			lane_next[i].sticky = |wide[max_shift-3:0];

			// Pass through
			lane_next[i].exponent = cur.exponent;
			lane_next[i].logical_subtract = cur.logical_subtract;
			lane_next[i].result_sign = cur.result_sign;
			lane_next[i].zero = cur.zero;
		end
	end

	// Lane data, no reset
	always_ff @(posedge clk)
	begin
		shift_lanes <= lane_next;
	end

	// Valid, mask and tag
	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			shift_ctl <= '0;
		end
		else
		begin
			shift_ctl <= align_ctl;
		end
	end

endmodule

// File: source/fp_add_sum.sv
/*
 * Adder stage 3: significand add or subtract per lane.
 * Subtract uses the one's complement of the aligned operand plus a
 * carry-in when the shifted-out part was exactly zero.
 */
`timescale 1ns/1ps

module fp_add_sum
	import fp_add_pkg::*;
(
	input  logic                        clk,
	input  logic                        reset,
	input  pipe_ctl_t                   shift_ctl,
	input  shift_lane_t [lanes-1:0]     shift_lanes,
	output pipe_ctl_t                   sum_ctl,
	output sum_lane_t [lanes-1:0]       sum_lanes
);

	sum_lane_t [lanes-1:0] lane_next;

	always_comb
	begin
		shift_lane_t cur;
		logic guard_c;
		logic round_c;
		logic carry_in;

		for (int i = 0; i < lanes; i++)
		begin
			cur = shift_lanes[i];

			// Guard and round complemented along with significand2 on subtract
			guard_c = cur.guard ^ cur.logical_subtract;
			round_c = cur.round ^ cur.logical_subtract;

			// Complemented guard and round both set, no sticky: +1 ripples into the sum
			carry_in = cur.logical_subtract && guard_c && round_c && !cur.sticky;
			lane_next[i].sum = {1'b0, cur.significand1}
				+ ({1'b0, cur.significand2} ^ {(sig_width+1){cur.logical_subtract}})
				+ {{sig_width{1'b0}}, carry_in};

			// Low bits end up as the exact difference when sticky is clear
			{lane_next[i].guard, lane_next[i].round} = {guard_c, round_c}
				+ {1'b0, cur.logical_subtract && !cur.sticky};
			lane_next[i].sticky = cur.sticky;

			lane_next[i].exponent = cur.exponent;
			lane_next[i].logical_subtract = cur.logical_subtract;
			lane_next[i].result_sign = cur.result_sign;
			lane_next[i].zero = cur.zero;
		end
	end

	always_ff @(posedge clk)
	begin
		sum_lanes <= lane_next;
	end

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			sum_ctl <= '0;
		end
		else
		begin
			sum_ctl <= shift_ctl;
		end
	end

	// Larger magnitude always comes first, so a subtract never carries out
	genvar lane_idx;
	generate
		for (lane_idx = 0; lane_idx < lanes; lane_idx++)
		begin : borrow_check
			assert property (@(posedge clk) disable iff (reset)
				sum_ctl.valid && sum_lanes[lane_idx].logical_subtract
					|-> !sum_lanes[lane_idx].sum[sig_width])
				else $error("Lane %0d subtract carried out at time %0t", lane_idx, $time);
		end
	endgenerate

endmodule

// File: source/fp_add_normalize.sv
/*
 * Adder stage 4: normalize, round and pack.
 * Carry-out shifts right, cancellation shifts left by the leading-zero
 * count, then round to nearest even with flush to zero and saturation.
 */
`timescale 1ns/1ps

module fp_add_normalize
	import fp_add_pkg::*;
(
	input  logic                        clk,
	input  logic                        reset,
	input  pipe_ctl_t                   sum_ctl,
	input  sum_lane_t [lanes-1:0]       sum_lanes,
	output pipe_ctl_t                   result_ctl,
	output fp_word_t [lanes-1:0]        result
);

	fp_word_t [lanes-1:0] result_next;

	// Leading zeros of sum plus guard and round, all zero gives the full width
	function automatic logic [shift_width-1:0] lead_zeros(input logic [sig_width+1:0] word);
		logic [shift_width-1:0] count;

		count = shift_width'(sig_width + 2);
		for (int b = 0; b < sig_width + 2; b++)
		begin
			if (word[b])
			begin
				count = shift_width'(sig_width + 1 - b);
			end
		end
		return count;
	endfunction

	always_comb
	begin
		sum_lane_t cur;
		logic [sig_width+1:0] frac_word;
		logic [sig_width+1:0] shifted;
		logic [shift_width-1:0] lz;
		logic [sig_width-1:0] mant;
		logic guard_n;
		logic round_n;
		logic sticky_n;
		logic round_up;
		logic [sig_width:0] mant_r;
		logic signed [exp_width+1:0] exp_pre;
		logic signed [exp_width+1:0] exp_fin;
		logic exact_zero;

		for (int i = 0; i < lanes; i++)
		begin
			cur = sum_lanes[i];

			// Guard and round take part in the left shift
			// Big shifts only follow close exponents so nothing below round is lost
			frac_word = {cur.sum[sig_width-1:0], cur.guard, cur.round};
			lz = lead_zeros(frac_word);
			shifted = frac_word << lz;

			if (cur.sum[sig_width])
			begin
				// Carry-out, one step right
				mant = cur.sum[sig_width:1];
				guard_n = cur.sum[0];
				round_n = cur.guard;
				sticky_n = cur.round | cur.sticky;
				exp_pre = $signed({2'b00, cur.exponent}) + 1;
			end
			else
			begin
				mant = shifted[sig_width+1:2];
				guard_n = shifted[1];
				round_n = shifted[0];
				sticky_n = cur.sticky;
				exp_pre = $signed({2'b00, cur.exponent})
					- $signed({{(exp_width+2-shift_width){1'b0}}, lz});
			end

			// Nearest even: above half, or exactly half with odd lsb
			round_up = guard_n && (round_n || sticky_n || mant[0]);
			mant_r = {1'b0, mant} + {{sig_width{1'b0}}, round_up};
			// Rounding overflow leaves 1.000, only the exponent moves
			exp_fin = exp_pre + $signed({{(exp_width+1){1'b0}}, mant_r[sig_width]});

			// Both zero, or a subtract that cancels every bit
			exact_zero = cur.zero
				|| (cur.logical_subtract && (frac_word == '0) && !cur.sticky);

			if (exact_zero || exp_fin <= 0)
			begin
				// Zero is always positive here
				result_next[i].bits = '0;
			end
			else if (exp_fin > $signed({2'b00, exp_max}))
			begin
				result_next[i].fields.sign = cur.result_sign;
				result_next[i].fields.exponent = exp_max;
				result_next[i].fields.fraction = '1;
			end
			else
			begin
				result_next[i].fields.sign = cur.result_sign;
				result_next[i].fields.exponent = exp_fin[exp_width-1:0];
				result_next[i].fields.fraction = mant_r[sig_width-2:0];
			end
		end
	end

	always_ff @(posedge clk)
	begin
		result <= result_next;
	end

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			result_ctl <= '0;
		end
		else
		begin
			result_ctl <= sum_ctl;
		end
	end

	// A left shift of two or more must find nothing below round
	genvar lane_idx;
	generate
		for (lane_idx = 0; lane_idx < lanes; lane_idx++)
		begin : shift_check
			assert property (@(posedge clk) disable iff (reset)
				sum_ctl.valid && (sum_lanes[lane_idx].sum[sig_width:sig_width-2] == '0)
					|-> !sum_lanes[lane_idx].round && !sum_lanes[lane_idx].sticky)
				else $error("Lane %0d lost bits in a deep left shift at time %0t",
					lane_idx, $time);
		end
	endgenerate

endmodule

// File: source/fp_add_pipeline.sv
/*
 * Four-stage vector floating-point add/subtract pipeline.
 * Align, shift, sum and normalize in a straight chain, one issue per cycle,
 * valid-only with no back-pressure.
 */
`timescale 1ns/1ps

module fp_add_pipeline
	import fp_add_pkg::*;
(
	input  logic                    clk,
	input  logic                    reset,
	input  pipe_ctl_t               issue_ctl,
	input  logic                    subtract,
	input  fp_word_t [lanes-1:0]    operand_a,
	input  fp_word_t [lanes-1:0]    operand_b,
	output pipe_ctl_t               result_ctl,
	output fp_word_t [lanes-1:0]    result
);

	// Stage 1 to 2
	pipe_ctl_t align_ctl;
	align_lane_t [lanes-1:0] align_lanes;

	// Stage 2 to 3
	pipe_ctl_t shift_ctl;
	shift_lane_t [lanes-1:0] shift_lanes;

	// Stage 3 to 4
	pipe_ctl_t sum_ctl;
	sum_lane_t [lanes-1:0] sum_lanes;

	fp_add_align align_stage (
		.clk         (clk),
		.reset       (reset),
		.issue_ctl   (issue_ctl),
		.subtract    (subtract),
		.operand_a   (operand_a),
		.operand_b   (operand_b),
		.align_ctl   (align_ctl),
		.align_lanes (align_lanes)
	);

	fp_add_shift shift_stage (
		.clk         (clk),
		.reset       (reset),
		.align_ctl   (align_ctl),
		.align_lanes (align_lanes),
		.shift_ctl   (shift_ctl),
		.shift_lanes (shift_lanes)
	);

	fp_add_sum sum_stage (
		.clk         (clk),
		.reset       (reset),
		.shift_ctl   (shift_ctl),
		.shift_lanes (shift_lanes),
		.sum_ctl     (sum_ctl),
		.sum_lanes   (sum_lanes)
	);

	// Last stage drives the result ports directly
	fp_add_normalize normalize_stage (
		.clk         (clk),
		.reset       (reset),
		.sum_ctl     (sum_ctl),
		.sum_lanes   (sum_lanes),
		.result_ctl  (result_ctl),
		.result      (result)
	);

endmodule

// File: bench/fp_add_checker.sv
/*
 * Result checker for the vector adder pipeline.
 * Holds expected results in issue order, compares every valid result
 * on the falling edge and keeps per-test and overall counts.
 */
`timescale 1ns/1ps

module fp_add_checker
	import fp_add_pkg::*;
(
	input  logic                    clk,
	input  logic                    reset,
	input  pipe_ctl_t               result_ctl,
	input  fp_word_t [lanes-1:0]    result
);

	// Expected entries, one per issue
	int test_q[$];
	int due_q[$];
	pipe_ctl_t ctl_q[$];
	logic [lanes*32-1:0] word_q[$];

	int cycle;
	int pending = 0;
	int checked_count = 0;
	int error_count = 0;
	int test_count = 0;
	int tests_failed = 0;
	int cur_test = -1;
	int cur_errors = 0;
	int cur_results = 0;

	// Rising edges since reset, used to time each result
	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			cycle <= 0;
		end
		else
		begin
			cycle <= cycle + 1;
		end
	end

	// Called in the cycle the issue is driven, result lands pipe_latency cycles later
	task automatic expect_result(input int test, input pipe_ctl_t ctl,
		input logic [lanes*32-1:0] words);
		test_q.push_back(test);
		due_q.push_back(cycle + pipe_latency);
		ctl_q.push_back(ctl);
		word_q.push_back(words);
		pending++;
	endtask

	// One summary line for the test just completed
	task automatic close_test();
		if (cur_test >= 0)
		begin
			test_count++;
			if (cur_errors != 0)
			begin
				tests_failed++;
			end
			$display("test %0d: %0d results, %0d errors", cur_test, cur_results, cur_errors);
		end
	endtask

	task automatic compare_result();
		int test;
		int due;
		pipe_ctl_t ctl;
		logic [lanes*32-1:0] words;
		logic [31:0] exp_word;

		if (test_q.size() == 0)
		begin
			$display("A result with tag %0h came out at %0t with no issue outstanding",
				result_ctl.tag, $time);
			error_count++;
			return;
		end
		test = test_q.pop_front();
		due = due_q.pop_front();
		ctl = ctl_q.pop_front();
		words = word_q.pop_front();
		pending--;

		// New test number closes the previous one
		if (test != cur_test)
		begin
			close_test();
			cur_test = test;
			cur_errors = 0;
			cur_results = 0;
		end
		cur_results++;
		checked_count++;

		// Exactly pipe_latency cycles after the issue cycle
		if (cycle != due)
		begin
			$display("error %0t: test %0d result at cycle %0d, expected cycle %0d",
				$time, test, cycle, due);
			cur_errors++;
		end
		if (result_ctl.tag !== ctl.tag || result_ctl.mask !== ctl.mask)
		begin
			$display("error %0t: test %0d tag/mask %0h/%0h, expected %0h/%0h", $time, test,
				result_ctl.tag, result_ctl.mask, ctl.tag, ctl.mask);
			cur_errors++;
		end

		// Masked-off lanes are not compared
		for (int l = 0; l < lanes; l++)
		begin
			exp_word = words[l*32 +: 32];
			if (ctl.mask[l] && result[l].bits !== exp_word)
			begin
				$display("error %0t: test %0d lane %0d got %08h, expected %08h",
					$time, test, l, result[l].bits, exp_word);
				cur_errors++;
			end
		end
	endtask

	// Outputs are registered, so the falling edge sees them settled
	always @(negedge clk)
	begin
		if (!reset && result_ctl.valid === 1'b1)
		begin
			compare_result();
		end
	end

	// Closing line with all counts
	task automatic finish_report();
		close_test();
		cur_test = -1;
		$display("Checked %0d results in %0d tests: %0d tests failed, %0d stray results",
			checked_count, test_count, tests_failed, error_count);
	endtask

endmodule

// File: bench/fp_add_tb.sv
/*
 * Testbench for the vector floating-point add/subtract pipeline.
 * Reads issues and expected results from the pattern file, drives them
 * with random idle gaps and leaves comparing to the checker.
 */
`timescale 1ns/1ps

module fp_add_tb
	import fp_add_pkg::*;
();

	localparam int clk_period = 20;
	localparam int drive_delay = 2;
	localparam int max_lines = 64;
	localparam int line_words = 16;

	logic clk;
	logic reset;
	pipe_ctl_t issue_ctl;
	logic subtract;
	fp_word_t [lanes-1:0] operand_a;
	fp_word_t [lanes-1:0] operand_b;
	pipe_ctl_t result_ctl;
	fp_word_t [lanes-1:0] result;

	// One line: test, subtract, mask, tag, four a, four b, four expected
	logic [31:0] pattern_mem [0:max_lines*line_words-1];
	int num_patterns = 0;
	int seed;

	fp_add_pipeline DUT (
		.clk        (clk),
		.reset      (reset),
		.issue_ctl  (issue_ctl),
		.subtract   (subtract),
		.operand_a  (operand_a),
		.operand_b  (operand_b),
		.result_ctl (result_ctl),
		.result     (result)
	);

	fp_add_checker chk (
		.clk        (clk),
		.reset      (reset),
		.result_ctl (result_ctl),
		.result     (result)
	);

	initial
	begin
		clk = 1'b0;
		forever #(clk_period/2) clk = ~clk;
	end

	// Step to the drive point just after the next rising edge
	task automatic next_drive_slot();
		@(posedge clk);
		#drive_delay;
	endtask

	// Put one pattern line on the issue port and hand its expectation over
	task automatic issue_pattern(input int p);
		int base;
		pipe_ctl_t ctl;
		logic [lanes*32-1:0] words;

		base = p * line_words;
		ctl.valid = 1'b1;
		ctl.mask = pattern_mem[base+2][lanes-1:0];
		ctl.tag = pattern_mem[base+3][tag_width-1:0];
		subtract = pattern_mem[base+1][0];
		for (int l = 0; l < lanes; l++)
		begin
			operand_a[l].bits = pattern_mem[base+4+l];
			operand_b[l].bits = pattern_mem[base+8+l];
			words[l*32 +: 32] = pattern_mem[base+12+l];
		end
		issue_ctl = ctl;
		chk.expect_result(pattern_mem[base], ctl, words);
	endtask

	initial
	begin
		seed = 32'h28ea_d06f;
		void'($urandom(seed));
		reset = 1'b1;
		issue_ctl = '0;
		subtract = 1'b0;
		operand_a = '0;
		operand_b = '0;

		// Unused entries stay unknown, which marks the end of the file
		for (int i = 0; i < max_lines * line_words; i++)
		begin
			pattern_mem[i] = 'x;
		end
		$readmemh("bench/fp_add_patterns.hex", pattern_mem);
		while (num_patterns < max_lines && !$isunknown(pattern_mem[num_patterns*line_words]))
		begin
			num_patterns++;
		end

		// Reset over three rising edges
		repeat (3) @(posedge clk);
		#drive_delay;
		reset = 1'b0;

		for (int p = 0; p < num_patterns; p++)
		begin
			issue_pattern(p);
			next_drive_slot();
			// Occasional idle cycle between issues
			if ($urandom % 2 == 1)
			begin
				issue_ctl.valid = 1'b0;
				next_drive_slot();
			end
		end
		issue_ctl.valid = 1'b0;

		// Checker drains its queue as results come out
		wait (chk.pending == 0);
		@(negedge clk);
		chk.finish_report();
		if (num_patterns > 0 && chk.checked_count == num_patterns
			&& chk.tests_failed == 0 && chk.error_count == 0)
		begin
			$display("Simulation passed");
		end
		else
		begin
			$display("Simulation failed");
		end
		$finish;
	end

	// At most one idle cycle per issue, plus drain time and margin
	initial
	begin
		wait (num_patterns > 0);
		#((num_patterns + pipe_latency + 20) * 2 * clk_period);
		$display("Timeout: %0d results never came out of the pipeline", chk.pending);
		$display("Simulation failed");
		$finish;
	end

endmodule

// File: src.f
source/fp_add_pkg.sv
source/fp_add_align.sv
source/fp_add_shift.sv
source/fp_add_sum.sv
source/fp_add_normalize.sv
source/fp_add_pipeline.sv
bench/fp_add_checker.sv
bench/fp_add_tb.sv

// File: bench/fp_add_patterns.hex
// test subtract mask tag | operand_a lanes 0..3 | operand_b lanes 0..3 | expected lanes 0..3
// Expected words in masked-off lanes are don't-care and hold DEADBEEF
// Test 1: same-sign addition, carry-out, one-ulp addend
1 0 F 1 3F800000 3F800000 3FC00000 40200000 3F800000 40000000 3FC00000 40A00000 40000000 40400000 40400000 40F00000
1 0 F 2 40400000 3F800000 3E800000 41200000 40800000 3F000000 3F400000 40C00000 40E00000 3FC00000 3F800000 41800000
1 0 F 3 BF800000 BF000000 41000000 3F800000 C0000000 BE800000 41000000 34000000 C0400000 BF400000 41800000 3F800001
// Test 2: subtract, mixed signs, deep cancellation, exact zero
2 1 F 4 40400000 3F800000 40A00000 3F800000 3F800000 40400000 40200000 3F400000 40000000 C0000000 40200000 3E800000
2 0 F 5 3F800000 C0800000 40000000 3FC00000 BF000000 3F800000 C0000000 BF800000 3F000000 C0400000 00000000 3F000000
2 1 F 6 3F800001 3F800000 40A00000 C0400000 3F800000 3F7FFFFF 40A00000 C0400000 34000000 33800000 00000000 00000000
// Test 3: nearest-even ties and sticky, add then subtract
3 0 F 7 3F800000 3F800001 3F800000 3FFFFFFF 33800000 33800000 33800001 3F800000 3F800000 3F800002 3F800001 40400000
3 1 F 8 3F800000 3F800000 3F800000 40000000 33C00000 33800000 32800000 33C00000 3F7FFFFE 3F7FFFFF 3F800000 3FFFFFFF
// Test 4: denormal flush, underflow, overflow saturation
4 0 F 9 00000001 00400000 80400000 00800001 3F800000 00400000 00000000 80800000 3F800000 00000000 00000000 00000000
4 0 F A 7F7FFFFF FF7FFFFF 7F000000 7F7FFFFF 7F7FFFFF FF7FFFFF 7F000000 73000000 7F7FFFFF FF7FFFFF 7F7FFFFF 7F7FFFFF
// Test 5: partial masks and changing tags back to back
5 0 5 3 3F800000 40000000 40400000 40800000 3F800000 3F800000 3F800000 3F800000 40000000 DEADBEEF 40800000 DEADBEEF
5 1 A 7 40A00000 40A00000 40A00000 40A00000 3F800000 40000000 40400000 40800000 DEADBEEF 40400000 DEADBEEF 3F800000
5 0 3 C 41200000 C1200000 00000000 00000000 41200000 41200000 00000000 00000000 41A00000 00000000 DEADBEEF DEADBEEF
5 1 C 1 00000000 00000000 3F000000 BF000000 00000000 00000000 3E800000 3E800000 DEADBEEF DEADBEEF 3E800000 BF400000
5 0 F E 3F800000 40000000 40400000 40800000 40000000 40400000 40800000 40A00000 40400000 40A00000 40E00000 41100000
5 1 1 0 42C80000 00000000 00000000 00000000 42C60000 00000000 00000000 00000000 3F800000 DEADBEEF DEADBEEF DEADBEEF
